/* src/cpuPkg.sv */
package cpuPkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASSB // lui
	} aluOp;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4,
		WB_PCIMM // auipc
	} wbSel;

	typedef enum logic [1:0] {
		PC_SEQ,
		PC_BEQ,
		PC_JAL,
		PC_JALR
	} pcSel;

	typedef enum logic [1:0] {
		MEM_BYTE,
		MEM_HALF,
		MEM_WORD
	} memSize;

	typedef struct packed {
		aluOp        aluOp;
		logic        aluSrcImm;
		wbSel        wbSel;
		logic        regWrite;
		logic        memRead;
		logic        memWrite;
		memSize      memSize;
		logic        loadUnsigned;
		pcSel        pcSel;
		logic [31:0] imm;
		logic        invalid;
		logic        halt;
	} ctrlBundle;

	typedef struct packed {
		logic        regWrite;
		logic [4:0]  rd;
		logic [31:0] wbData;
		logic [31:0] nextPc;
	} retireInfo;

endpackage

/* src/instDecoder.sv */
module instDecoder (
	input  logic [31:0]       inst,
	output cpuPkg::ctrlBundle ctrl
);
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011
	} opcodeT;

	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [31:0] immI, immS, immB, immU, immJ;

	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		ctrl = '0; // defaults to a sequential no-op
		ctrl.aluOp = cpuPkg::ALU_ADD;
		ctrl.wbSel = cpuPkg::WB_ALU;
		ctrl.pcSel = cpuPkg::PC_SEQ;
		ctrl.memSize = cpuPkg::MEM_WORD;
		case (opcodeT'(inst[6:0]))
			OP_LUI: begin
				ctrl.aluOp = cpuPkg::ALU_PASSB;
				ctrl.aluSrcImm = 1'b1;
				ctrl.imm = immU;
				ctrl.regWrite = 1'b1;
			end
			OP_AUIPC: begin
				ctrl.imm = immU;
				ctrl.wbSel = cpuPkg::WB_PCIMM;
				ctrl.regWrite = 1'b1;
			end
			OP_JAL: begin
				ctrl.imm = immJ;
				ctrl.wbSel = cpuPkg::WB_PC4;
				ctrl.pcSel = cpuPkg::PC_JAL;
				ctrl.regWrite = 1'b1;
			end
			OP_JALR: begin
				ctrl.imm = immI;
				ctrl.aluSrcImm = 1'b1;
				ctrl.wbSel = cpuPkg::WB_PC4;
				ctrl.pcSel = cpuPkg::PC_JALR;
				ctrl.regWrite = 1'b1;
				ctrl.invalid = funct3 != 3'b000;
			end
			OP_BRANCH: begin
				ctrl.imm = immB;
				ctrl.aluOp = cpuPkg::ALU_SUB;
				ctrl.pcSel = cpuPkg::PC_BEQ;
				ctrl.invalid = funct3 != 3'b000; // beq only
			end
			OP_LOAD: begin
				ctrl.imm = immI;
				ctrl.aluSrcImm = 1'b1;
				ctrl.wbSel = cpuPkg::WB_MEM;
				ctrl.memRead = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memSize = cpuPkg::memSize'(funct3[1:0]);
				ctrl.loadUnsigned = funct3[2];
				ctrl.invalid = funct3[1:0] == 2'b11 || (funct3[2] && funct3[1]);
			end
			OP_STORE: begin
				ctrl.imm = immS;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.memSize = cpuPkg::memSize'(funct3[1:0]);
				ctrl.invalid = funct3[2] || funct3[1:0] == 2'b11;
			end
			OP_IMM: begin
				ctrl.imm = immI;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct3)
					3'b000: ctrl.aluOp = cpuPkg::ALU_ADD;
					3'b010: ctrl.aluOp = cpuPkg::ALU_SLT;
					3'b011: ctrl.aluOp = cpuPkg::ALU_SLTU;
					3'b100: ctrl.aluOp = cpuPkg::ALU_XOR;
					3'b110: ctrl.aluOp = cpuPkg::ALU_OR;
					3'b111: ctrl.aluOp = cpuPkg::ALU_AND;
					default: ctrl.invalid = 1'b1; // no shift-immediates
				endcase
			end
			OP_REG: begin
				ctrl.regWrite = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: ctrl.aluOp = cpuPkg::ALU_ADD;
					10'b0100000_000: ctrl.aluOp = cpuPkg::ALU_SUB;
					10'b0000000_001: ctrl.aluOp = cpuPkg::ALU_SLL;
					10'b0000000_010: ctrl.aluOp = cpuPkg::ALU_SLT;
					10'b0000000_011: ctrl.aluOp = cpuPkg::ALU_SLTU;
					10'b0000000_100: ctrl.aluOp = cpuPkg::ALU_XOR;
					10'b0000000_101: ctrl.aluOp = cpuPkg::ALU_SRL;
					10'b0100000_101: ctrl.aluOp = cpuPkg::ALU_SRA;
					10'b0000000_110: ctrl.aluOp = cpuPkg::ALU_OR;
					10'b0000000_111: ctrl.aluOp = cpuPkg::ALU_AND;
					default: ctrl.invalid = 1'b1;
				endcase
			end
			default: begin
				ctrl.halt = inst == 32'h0010_0073; // ebreak
				ctrl.invalid = !ctrl.halt;
			end
		endcase
		if (ctrl.invalid) begin
			ctrl.regWrite = 1'b0;
			ctrl.memWrite = 1'b0;
			ctrl.memRead = 1'b0;
			ctrl.pcSel = cpuPkg::PC_SEQ;
		end
	end
endmodule

/* src/registerFile.sv */
module registerFile (
	input  logic        clk,
	input  logic        reset,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic        we,
	input  logic [31:0] wdata,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);
	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	assign rdata1 = regs[rs1];
	assign rdata2 = regs[rs2];

	// x0 reads zero after every edge
	assert property (@(posedge clk) disable iff (reset) regs[0] == 32'd0);
endmodule

/* src/alu.sv */
module alu (
	input  cpuPkg::aluOp op,
	input  logic [31:0]  a,
	input  logic [31:0]  b,
	output logic [31:0]  result,
	output logic         zero
);
	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			cpuPkg::ALU_ADD:   result = a + b;
			cpuPkg::ALU_SUB:   result = a - b;
			cpuPkg::ALU_SLL:   result = a << shamt;
			cpuPkg::ALU_SLT:   result = {31'b0, $signed(a) < $signed(b)};
			cpuPkg::ALU_SLTU:  result = {31'b0, a < b};
			cpuPkg::ALU_XOR:   result = a ^ b;
			cpuPkg::ALU_SRL:   result = a >> shamt;
			cpuPkg::ALU_SRA:   result = $unsigned($signed(a) >>> shamt);
			cpuPkg::ALU_OR:    result = a | b;
			cpuPkg::ALU_AND:   result = a & b;
			cpuPkg::ALU_PASSB: result = b;
			default:           result = '0;
		endcase
	end

	assign zero = result == 32'd0; // beq after sub
endmodule

/* src/dataMemory.sv */
module dataMemory #(
	parameter int MEM_WORDS = 1024
) (
	input  logic           clk,
	input  logic [31:0]    addr,
	input  logic [31:0]    wdata,
	input  logic           we,
	input  cpuPkg::memSize size,
	input  logic           loadUnsigned,
	output logic [31:0]    rdata
);
	localparam int AW = $clog2(MEM_WORDS);

	logic [31:0] mem [MEM_WORDS];
	logic [AW-1:0] index;
	logic [1:0] offset;
	logic [3:0] laneMask;
	logic [31:0] laneData;
	logic [31:0] word;
	logic [31:0] shifted;

	assign index = addr[AW+1:2]; // wraps modulo MEM_WORDS
	assign offset = addr[1:0];

	always_comb begin
		case (size)
			cpuPkg::MEM_BYTE: begin
				laneMask = 4'b0001 << offset;
				laneData = {4{wdata[7:0]}};
			end
			cpuPkg::MEM_HALF: begin
				laneMask = 4'b0011 << offset;
				laneData = {2{wdata[15:0]}};
			end
			default: begin
				laneMask = 4'b1111;
				laneData = wdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (we && laneMask[i]) mem[index][i*8 +: 8] <= laneData[i*8 +: 8];
		end
	end

	assign word = mem[index];
	assign shifted = word >> {offset, 3'b000};

	always_comb begin
		case (size)
			cpuPkg::MEM_BYTE: rdata = {{24{!loadUnsigned && shifted[7]}}, shifted[7:0]};
			cpuPkg::MEM_HALF: rdata = {{16{!loadUnsigned && shifted[15]}}, shifted[15:0]};
			default:          rdata = word;
		endcase
	end

	assert property (@(posedge clk)
		we |-> (size != cpuPkg::MEM_HALF || !addr[0]) && (size != cpuPkg::MEM_WORD || offset == 2'b00));
endmodule

/* src/pcUnit.sv */
module pcUnit #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic         clk,
	input  logic         reset,
	input  cpuPkg::pcSel sel,
	input  logic [31:0]  imm,
	input  logic [31:0]  jumpBase,
	input  logic         zero,
	input  logic         hold,
	output logic [31:0]  pc,
	output logic [31:0]  pcPlus4,
	output logic [31:0]  nextPc
);
	logic [31:0] target;
	logic [31:0] computed;

	assign pcPlus4 = pc + 32'd4;
	assign target = pc + imm; // beq and jal

	always_comb begin
		case (sel)
			cpuPkg::PC_BEQ:  computed = zero ? target : pcPlus4;
			cpuPkg::PC_JAL:  computed = target;
			cpuPkg::PC_JALR: computed = {jumpBase[31:1], 1'b0};
			default:         computed = pcPlus4;
		endcase
	end

	assign nextPc = hold ? pc : computed;

	always_ff @(posedge clk) begin
		if (reset) pc <= RESET_PC;
		else pc <= nextPc;
	end

	assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);
endmodule

/* src/cpuCore.sv */
module cpuCore #(
	parameter logic [31:0] RESET_PC  = 32'h0,
	parameter int          MEM_WORDS = 1024
) (
	input  logic              clk,
	input  logic              reset,
	output logic [31:0]       pc,
	input  logic [31:0]       inst,
	output cpuPkg::retireInfo retire,
	output logic              memWrite,
	output logic              invalid,
	output logic              halted
);
	cpuPkg::ctrlBundle ctrl;
	logic haltSeen; // sticky until reset
	logic regWrite;
	logic [31:0] rdata1, rdata2, aluB, aluResult;
	logic zero;
	logic [31:0] memRdata, loadData;
	logic [31:0] pcPlus4, pcImm, nextPc, wbData;

	instDecoder decoder (.inst(inst), .ctrl(ctrl));

	always_ff @(posedge clk) begin
		if (reset) haltSeen <= 1'b0;
		else if (ctrl.halt) haltSeen <= 1'b1;
	end

	assign halted = haltSeen || ctrl.halt;
	assign invalid = ctrl.invalid;
	assign regWrite = ctrl.regWrite && !halted;
	assign memWrite = ctrl.memWrite && !halted;

	registerFile regs (
		.clk(clk), .reset(reset),
		.rs1(inst[19:15]), .rs2(inst[24:20]), .rd(inst[11:7]),
		.we(regWrite), .wdata(wbData),
		.rdata1(rdata1), .rdata2(rdata2)
	);

	assign aluB = ctrl.aluSrcImm ? ctrl.imm : rdata2;

	alu alu0 (.op(ctrl.aluOp), .a(rdata1), .b(aluB), .result(aluResult), .zero(zero));

	dataMemory #(.MEM_WORDS(MEM_WORDS)) dmem (
		.clk(clk), .addr(aluResult), .wdata(rdata2), .we(memWrite),
		.size(ctrl.memSize), .loadUnsigned(ctrl.loadUnsigned), .rdata(memRdata)
	);

	assign loadData = ctrl.memRead ? memRdata : 32'd0;

	pcUnit #(.RESET_PC(RESET_PC)) pcu (
		.clk(clk), .reset(reset), .sel(ctrl.pcSel), .imm(ctrl.imm),
		.jumpBase(aluResult), .zero(zero), .hold(halted),
		.pc(pc), .pcPlus4(pcPlus4), .nextPc(nextPc)
	);

	assign pcImm = pc + ctrl.imm; // auipc

	always_comb begin
		case (ctrl.wbSel)
			cpuPkg::WB_MEM:   wbData = loadData;
			cpuPkg::WB_PC4:   wbData = pcPlus4;
			cpuPkg::WB_PCIMM: wbData = pcImm;
			default:          wbData = aluResult;
		endcase
	end

	assign retire = '{regWrite: regWrite, rd: inst[11:7], wbData: wbData, nextPc: nextPc};
endmodule

/* include/cpuModel.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [31:0] prog [PROG_LEN];
logic [31:0] xreg [32];
logic [31:0] dmemModel [MODEL_WORDS];
logic [31:0] mPc;
logic mHalted;
logic [31:0] lfsr = 32'he6a6_76ef;
cpuPkg::retireInfo expRetire;
logic expMemWrite;
logic expInvalid;
logic expHalt;

// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic logic [31:0] randBits(input int n);
	logic [31:0] r;
	r = 32'd0;
	for (int i = 0; i < n; i++) begin
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		r = {r[30:0], lfsr[0]};
	end
	return r;
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [2:0] f3);
	return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011}; // base is always x0
endfunction

function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs1,
	input logic [4:0] rs2, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

task automatic buildProgram();
	int kind;
	int k;
	int pick;
	logic [4:0] rd, rs1, rs2, off;
	logic [2:0] f3;
	logic [6:0] f7;
	logic [31:0] target;
	for (int i = 0; i < PROG_LEN - 1; i++) begin
		rd = 5'(randBits(5));
		rs1 = 5'(randBits(5));
		rs2 = 5'(randBits(5));
		k = 1 + int'(randBits(3)); // forward distance in words
		if (i + k > PROG_LEN - 1) k = PROG_LEN - 1 - i;
		kind = int'(randBits(6));
		if (i < MODEL_WORDS) begin
			prog[i] = encS(12'(i * 4), 5'd0, 3'b010); // prologue fills the data words
		end else if (kind < 16) begin
			f3 = 3'(randBits(3));
			f7 = ((f3 == 3'd0 || f3 == 3'd5) && randBits(1) != 32'd0) ? 7'h20 : 7'h00;
			prog[i] = {f7, rs2, rs1, f3, rd, 7'b0110011};
		end else if (kind < 32) begin
			f3 = 3'(randBits(3));
			if (f3 == 3'd1 || f3 == 3'd5) f3 = 3'd0;
			prog[i] = encI(12'(randBits(12)), rs1, f3, rd, 7'b0010011);
		end else if (kind < 46) begin
			pick = int'(randBits(3)) % 5;
			f3 = kind < 39 ? 3'(pick < 3 ? pick : pick + 1) : 3'(pick % 3);
			off = 5'(randBits(5));
			if (f3[1:0] == 2'd1) off[0] = 1'b0;
			if (f3[1:0] == 2'd2) off[1:0] = 2'b00;
			if (kind < 39) prog[i] = encI({7'd0, off}, 5'd0, f3, rd, 7'b0000011);
			else prog[i] = encS({7'd0, off}, rs2, f3);
		end else if (kind < 50) begin
			if (randBits(1) != 32'd0) rs2 = rs1; // taken for sure
			prog[i] = encB(13'(k * 4), rs1, rs2, 3'b000);
		end else if (kind < 52) begin
			prog[i] = encJ(21'(k * 4), rd);
		end else if (kind < 54) begin
			target = RESET_PC + 32'((i + k) * 4) + randBits(1); // odd sometimes
			prog[i] = encI(target[11:0], 5'd0, 3'b000, rd, 7'b1100111);
		end else if (kind < 57) begin
			prog[i] = {20'(randBits(20)), rd, 7'b0110111};
		end else if (kind < 61) begin
			prog[i] = {20'(randBits(20)), rd, 7'b0010111};
		end else if (randBits(1) != 32'd0) begin
			prog[i] = {25'(randBits(25)), 7'b0001011}; // custom-0, not decoded
		end else begin
			prog[i] = encB(13'(k * 4), rs1, rs2, 3'b001); // bne is left out
		end
	end
	prog[PROG_LEN - 1] = 32'h0010_0073; // ebreak
endtask

task automatic modelReset();
	for (int i = 0; i < 32; i++) begin
		xreg[i] = 32'd0;
	end
	mPc = RESET_PC;
	mHalted = 1'b0;
endtask

function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
	input logic [31:0] a, input logic [31:0] b);
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return {31'd0, $signed(a) < $signed(b)};
		3'd3: return {31'd0, a < b};
		3'd4: return a ^ b;
		3'd5: begin
			if (alt) return $unsigned($signed(a) >>> b[4:0]);
			return a >> b[4:0];
		end
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

// predicts one retire from the current state, then commits it
task automatic modelStep(input logic [31:0] w);
	logic [2:0] f3;
	logic [31:0] a, b, immI, immS, immB, immJ, immU, addr, lane;
	f3 = w[14:12];
	a = xreg[w[19:15]];
	b = xreg[w[24:20]];
	immI = {{20{w[31]}}, w[31:20]};
	immS = {{20{w[31]}}, w[31:25], w[11:7]};
	immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
	immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
	immU = {w[31:12], 12'd0};
	expRetire = '{regWrite: 1'b0, rd: w[11:7], wbData: 32'd0, nextPc: mPc + 32'd4};
	expMemWrite = 1'b0;
	expInvalid = 1'b0;
	expHalt = 1'b0;
	case (w[6:0])
		7'b0110111: begin
			expRetire.regWrite = 1'b1;
			expRetire.wbData = immU;
		end
		7'b0010111: begin
			expRetire.regWrite = 1'b1;
			expRetire.wbData = mPc + immU;
		end
		7'b1101111: begin
			expRetire.regWrite = 1'b1;
			expRetire.wbData = mPc + 32'd4;
			expRetire.nextPc = mPc + immJ;
		end
		7'b1100111: begin
			expRetire.regWrite = 1'b1;
			expRetire.wbData = mPc + 32'd4;
			expRetire.nextPc = (a + immI) & ~32'd1;
		end
		7'b1100011: begin
			if (f3 != 3'd0) expInvalid = 1'b1;
			else if (a == b) expRetire.nextPc = mPc + immB;
		end
		7'b0000011: begin
			addr = a + immI;
			lane = dmemModel[addr[4:2]] >> {addr[1:0], 3'b000};
			expRetire.regWrite = 1'b1;
			case (f3)
				3'd0: expRetire.wbData = {{24{lane[7]}}, lane[7:0]};
				3'd1: expRetire.wbData = {{16{lane[15]}}, lane[15:0]};
				3'd4: expRetire.wbData = {24'd0, lane[7:0]};
				3'd5: expRetire.wbData = {16'd0, lane[15:0]};
				default: expRetire.wbData = lane;
			endcase
		end
		7'b0100011: begin
			addr = a + immS;
			lane = dmemModel[addr[4:2]];
			case (f3)
				3'd0: lane[{addr[1:0], 3'b000} +: 8] = b[7:0];
				3'd1: lane[{addr[1:0], 3'b000} +: 16] = b[15:0];
				default: lane = b;
			endcase
			dmemModel[addr[4:2]] = lane;
			expMemWrite = 1'b1;
		end
		7'b0010011: begin
			expRetire.regWrite = 1'b1;
			expRetire.wbData = aluRef(f3, 1'b0, a, immI);
			if (f3 == 3'd1 || f3 == 3'd5) expInvalid = 1'b1;
		end
		7'b0110011: begin
			expRetire.regWrite = 1'b1;
			expRetire.wbData = aluRef(f3, w[30], a, b);
			if (w[31:25] != 7'h00 && !(w[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
				expInvalid = 1'b1;
		end
		7'b1110011: begin
			if (w == 32'h0010_0073) begin
				expHalt = 1'b1;
				expRetire.nextPc = mPc; // pc holds from here on
			end else begin
				expInvalid = 1'b1;
			end
		end
		default: expInvalid = 1'b1;
	endcase
	if (expInvalid) begin
		expRetire.regWrite = 1'b0;
		expMemWrite = 1'b0;
		expRetire.nextPc = mPc + 32'd4;
	end
	if (expRetire.regWrite && expRetire.rd != 5'd0) xreg[expRetire.rd] = expRetire.wbData;
	mPc = expRetire.nextPc;
	mHalted = expHalt;
endtask

`endif

/* test/cpuTb.sv */
module cpuTb;
	localparam logic [31:0] RESET_PC = 32'h0000_0100;
	localparam int MEM_WORDS = 256;
	localparam int PROG_LEN = 300;
	localparam int MODEL_WORDS = 8; // data words at addresses 0..31
	localparam int MAX_CYCLES = 2000;

	logic clk;
	logic reset;
	logic [31:0] inst;
	logic [31:0] pc;
	cpuPkg::retireInfo retire;
	logic memWrite;
	logic invalid;
	logic halted;
	int cycle;

	`include "cpuModel.svh"

	cpuCore #(.RESET_PC(RESET_PC), .MEM_WORDS(MEM_WORDS)) DUT (
		.clk(clk), .reset(reset), .pc(pc), .inst(inst), .retire(retire),
		.memWrite(memWrite), .invalid(invalid), .halted(halted)
	);

	always #5 clk = ~clk;

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// instruction supply, indexed by the pc the core drives
	task automatic driveInst();
		logic [31:0] offset;
		offset = pc - RESET_PC;
		if (pc >= RESET_PC && offset < PROG_LEN * 4) inst = prog[offset >> 2];
		else inst = 32'd0;
	endtask

	task automatic retireOne();
		string tag;
		tag = $sformatf("inst %h at pc %h", inst, mPc);
		checkValue({tag, " pc"}, mPc, pc);
		modelStep(inst);
		checkValue({tag, " invalid"}, 32'(expInvalid), 32'(invalid));
		checkValue({tag, " halted"}, 32'(expHalt), 32'(halted));
		checkValue({tag, " memWrite"}, 32'(expMemWrite), 32'(memWrite));
		checkValue({tag, " regWrite"}, 32'(expRetire.regWrite), 32'(retire.regWrite));
		if (expRetire.regWrite) begin
			checkValue({tag, " rd"}, 32'(expRetire.rd), 32'(retire.rd));
			checkValue({tag, " wbData"}, expRetire.wbData, retire.wbData);
		end
		checkValue({tag, " nextPc"}, expRetire.nextPc, retire.nextPc);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		inst = 32'h0000_0013; // nop during reset
		buildProgram();
		modelReset();
		repeat (16) @(negedge clk);
		reset = 1'b0;
		checkValue("reset pc", RESET_PC, pc);
		checkValue("reset halted", 32'd0, 32'(halted));
		cycle = 0;
		while (!mHalted) begin
			if (cycle == MAX_CYCLES) begin
				$display("timeout: core did not halt within %0d cycles", MAX_CYCLES);
				$display("test failed");
				$fatal(1, "no halt");
			end
			driveInst();
			#3; // settled mid-cycle
			retireOne();
			@(negedge clk);
			cycle++;
		end
		repeat (10) begin
			driveInst();
			#3;
			checkValue("halt pc", mPc, pc);
			checkValue("halt halted", 32'd1, 32'(halted));
			checkValue("halt regWrite", 32'd0, 32'(retire.regWrite));
			checkValue("halt memWrite", 32'd0, 32'(memWrite));
			@(negedge clk);
		end
		$display("test passed");
		$finish;
	end
endmodule

/* project.f */
+incdir+include
src/cpuPkg.sv
src/instDecoder.sv
src/registerFile.sv
src/alu.sv
src/dataMemory.sv
src/pcUnit.sv
src/cpuCore.sv
test/cpuTb.sv
